/* Makefile */
# Verilator build and run for the multiply-add pipeline
#   make run      build if needed, simulate, check the log
#   make clean    remove build output and log

TOP       ?= madd_pipeline_tb
VERILATOR ?= verilator
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

FILELIST := build.f
SOURCES  := $(shell grep -v '^+' $(FILELIST)) rtl/madd_macros.svh
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* build.f */
+incdir+rtl
rtl/arith_pkg.sv
rtl/sched_pkg.sv
rtl/sched_delay_reg.sv
rtl/pipe_multiplier.sv
rtl/pipe_addsub.sv
rtl/madd_pipeline.sv
sim/madd_pipeline_tb.sv

/* rtl/arith_pkg.sv */
`include "madd_macros.svh"

package arith_pkg;

  // One operand as it enters the multiplier
  typedef logic [`MADD_WIDTH-1:0] word_t;

  // Products and final results use the full double width
  typedef logic [2*`MADD_WIDTH-1:0] result_t;

  // Selects what happens to the addend in the last stage
  typedef enum logic {
    OP_ADD = 1'b0, // a*b + c
    OP_SUB = 1'b1 // a*b - c, wraps modulo 2**32
  } op_t;

endpackage

/* rtl/madd_macros.svh */
`ifndef MADD_MACROS_SVH
`define MADD_MACROS_SVH

// ##################################################
// Datapath widths
// ##################################################

`define MADD_WIDTH 16 // Operand width, the product is twice this
`define MADD_TAG_WIDTH 4 // Caller tag carried beside each operation

// ##################################################
// Fixed schedule, counted in clock cycles
// ##################################################

`define MADD_MUL_LAT 3 // From go to prod_valid
`define MADD_LAT 4 // From go to done, multiplier plus the add stage

`endif

/* rtl/madd_pipeline.sv */
`timescale 1ns/1ns
`include "madd_macros.svh"

module madd_pipeline
  import arith_pkg::*, sched_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic go,
  input word_t a,
  input word_t b,
  input word_t c,
  input op_t op,
  input tag_t tag,
  output logic done,
  output result_t result,
  output tag_t tag_out
);

  result_t product;
  logic prod_valid;
  word_t c_dly; // Addend, arrives with the product
  logic [0:0] op_dly;
  tag_t tag_dly;

  pipe_multiplier mul (
    .clk(clk),
    .reset(reset),
    .go(go),
    .a(a),
    .b(b),
    .product(product),
    .prod_valid(prod_valid)
  );

  // ##################################################
  // Side values wait for the multiplier
  // ##################################################

  sched_delay_reg #(.WIDTH(`MADD_WIDTH), .DELAY(`MADD_MUL_LAT)) c_align (
    .clk(clk), .reset(reset), .write_en(go), .in(c), .out(c_dly)
  );

  sched_delay_reg #(.WIDTH(1), .DELAY(`MADD_MUL_LAT)) op_align (
    .clk(clk), .reset(reset), .write_en(go), .in(op), .out(op_dly)
  );

  sched_delay_reg #(.WIDTH(`MADD_TAG_WIDTH), .DELAY(`MADD_MUL_LAT)) tag_align (
    .clk(clk), .reset(reset), .write_en(go), .in(tag), .out(tag_dly)
  );

  // Matches the single add stage so tag_out changes together with result
  sched_delay_reg #(.WIDTH(`MADD_TAG_WIDTH), .DELAY(1)) tag_out_reg (
    .clk(clk), .reset(reset), .write_en(prod_valid), .in(tag_dly), .out(tag_out)
  );

  pipe_addsub addsub (
    .clk(clk),
    .reset(reset),
    .product(product),
    .prod_valid(prod_valid),
    .addend(c_dly),
    .op(op_t'(op_dly)),
    .result(result),
    .done(done)
  );

endmodule

/* rtl/pipe_addsub.sv */
`timescale 1ns/1ns

module pipe_addsub
  import arith_pkg::*;
(
  input logic clk,
  input logic reset,
  input result_t product,
  input logic prod_valid,
  input word_t addend,
  input op_t op,
  output result_t result,
  output logic done
);

  always_ff @(posedge clk) begin
    if (reset) begin
      result <= '0;
      done <= 1'b0;
    end else begin
      done <= prod_valid; // One done per product, never stretched
      if (prod_valid) begin
        if (op == OP_SUB) begin
          result <= product - result_t'(addend); // Wraps when addend exceeds product
        end else begin
          result <= product + result_t'(addend);
        end
      end
    end
  end

endmodule

/* rtl/pipe_multiplier.sv */
`timescale 1ns/1ns
`include "madd_macros.svh"

module pipe_multiplier
  import arith_pkg::*, sched_pkg::*;
(
  input logic clk,
  input logic reset,
  input logic go,
  input word_t a,
  input word_t b,
  output result_t product,
  output logic prod_valid
);

  localparam int HALF = `MADD_WIDTH / 2;

  word_t a_q; // Stage 1 operands
  word_t b_q;
  logic [`MADD_WIDTH+HALF-1:0] pp_lo; // Stage 2, a times low half of b
  logic [`MADD_WIDTH+HALF-1:0] pp_hi; // Stage 2, a times high half of b
  stage_valid_t stage_valid;

  // ##################################################
  // Data stages
  // ##################################################

  always_ff @(posedge clk) begin
    a_q <= a;
    b_q <= b;
  end

  always_ff @(posedge clk) begin
    pp_lo <= a_q * b_q[HALF-1:0];
    pp_hi <= a_q * b_q[`MADD_WIDTH-1:HALF];
  end

  always_ff @(posedge clk) begin
    product <= result_t'(pp_lo) + (result_t'(pp_hi) << HALF);
  end

  // Valid bits travel with the data, one operation per stage
  always_ff @(posedge clk) begin
    if (reset) begin
      stage_valid <= '0;
    end else begin
      stage_valid <= {stage_valid[`MADD_MUL_LAT-2:0], go};
    end
  end

  assign prod_valid = stage_valid[`MADD_MUL_LAT-1];

  // Each product leaves the pipe together with the operands of its own go
  a_mul_latency: assert property (@(posedge clk) disable iff (reset)
    $past(go, `MADD_MUL_LAT) |-> prod_valid &&
      product == result_t'($past(a, `MADD_MUL_LAT)) * result_t'($past(b, `MADD_MUL_LAT)))
    else $error("pipe_multiplier: product or prod_valid out of step with go");

endmodule

/* rtl/sched_delay_reg.sv */
`timescale 1ns/1ns

module sched_delay_reg #(
  parameter int WIDTH = 32,
  parameter int DELAY = 0
) (
  input logic clk,
  input logic reset,
  input logic write_en,
  input logic [WIDTH-1:0] in, // Sampled on the edge that ends a write_en cycle
  output logic [WIDTH-1:0] out // Valid DELAY cycles after write_en, held until the next write
);

  generate
    if (DELAY == 0) begin : g_pass
      logic [WIDTH-1:0] held;

      always_ff @(posedge clk) begin
        if (reset) begin
          held <= '0;
        end else if (write_en) begin
          held <= in;
        end
      end

      assign out = write_en ? in : held; // Same-cycle value while writing
    end else if (DELAY == 1) begin : g_reg
      always_ff @(posedge clk) begin
        if (reset) begin
          out <= '0;
        end else if (write_en) begin
          out <= in;
        end
      end
    end else if (DELAY == 2) begin : g_two
      logic sample_en;
      logic [WIDTH-1:0] sample;

      always_ff @(posedge clk) begin
        if (reset) begin
          sample_en <= 1'b0;
        end else begin
          sample_en <= write_en;
        end
      end

      always_ff @(posedge clk) begin
        sample <= in; // Captured every cycle, only used when sample_en says so
      end

      always_ff @(posedge clk) begin
        if (reset) begin
          out <= '0;
        end else if (sample_en) begin
          out <= sample;
        end
      end
    end else begin : g_line
      // Each write travels down its own slot, so one write per cycle is fine
      logic [DELAY-2:0] fsm;
      logic [WIDTH-1:0] line [DELAY-1];

      always_ff @(posedge clk) begin
        if (reset) begin
          fsm <= '0;
        end else begin
          fsm[0] <= write_en;
          for (int i = 1; i < DELAY - 1; i++) begin
            fsm[i] <= fsm[i-1];
          end
        end
      end

      always_ff @(posedge clk) begin
        line[0] <= in;
        for (int i = 1; i < DELAY - 1; i++) begin
          line[i] <= line[i-1];
        end
      end

      always_ff @(posedge clk) begin
        if (reset) begin
          out <= '0;
        end else if (fsm[DELAY-2]) begin
          out <= line[DELAY-2]; // Final stage holds between writes
        end
      end
    end
  endgenerate

  // ##################################################
  // Schedule check
  // ##################################################

  generate
    if (DELAY >= 2) begin : g_check
      a_delayed_value: assert property (@(posedge clk) disable iff (reset)
        $past(write_en, DELAY) |-> out == $past(in, DELAY))
        else $error("sched_delay_reg: value did not arrive %0d cycles after write", DELAY);
    end
  endgenerate

endmodule

/* rtl/sched_pkg.sv */
`include "madd_macros.svh"

package sched_pkg;

  // Opaque to the pipeline, it comes back out with the result
  typedef logic [`MADD_TAG_WIDTH-1:0] tag_t;

  // Bit i is set when multiplier stage i+1 holds a live operation
  typedef logic [`MADD_MUL_LAT-1:0] stage_valid_t;

endpackage

/* sim/madd_pipeline_tb.sv */
`timescale 1ns/1ns
`include "madd_macros.svh"

module madd_pipeline_tb
  import arith_pkg::*, sched_pkg::*;
;

  localparam int N_FIXED = 12;
  localparam int N_ENTRIES = N_FIXED + 20;

  logic clk;
  logic reset;
  logic go;
  word_t a;
  word_t b;
  word_t c;
  op_t op;
  tag_t tag;
  logic done;
  result_t result;
  tag_t tag_out;

  // Stimulus table, one column per field
  word_t tbl_a [N_ENTRIES];
  word_t tbl_b [N_ENTRIES];
  word_t tbl_c [N_ENTRIES];
  op_t tbl_op [N_ENTRIES];
  tag_t tbl_tag [N_ENTRIES];
  int tbl_gap [N_ENTRIES];

  result_t exp_result [$];
  tag_t exp_tag [$];
  int exp_edge [$]; // Edge count when each go pulse was raised

  integer seed = 19384;
  bit table_ready = 0;
  int cycle = 0;
  int errors = 0;
  int checks = 0;
  int go_count = 0;
  int done_count = 0;
  result_t last_result = '0;
  tag_t last_tag = '0;

  madd_pipeline uut (
    .clk(clk), .reset(reset), .go(go), .a(a), .b(b), .c(c), .op(op), .tag(tag),
    .done(done), .result(result), .tag_out(tag_out)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic check_value(input string name, input result_t got, input result_t exp);
    checks++;
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle);
      errors++;
    end
  endtask

  // a*b+c or a*b-c, kept to 32 bits
  function automatic result_t expected_result(word_t x, word_t y, word_t z, op_t sel);
    result_t prod;
    prod = result_t'(x) * result_t'(y);
    return (sel == OP_SUB) ? prod - result_t'(z) : prod + result_t'(z);
  endfunction

  task automatic set_entry(input int i, input word_t x, input word_t y, input word_t z,
                           input op_t sel, input tag_t t, input int gap);
    tbl_a[i] = x;
    tbl_b[i] = y;
    tbl_c[i] = z;
    tbl_op[i] = sel;
    tbl_tag[i] = t;
    tbl_gap[i] = gap;
  endtask

  task automatic fill_table();
    set_entry(0, 16'h0003, 16'h0005, 16'h0007, OP_ADD, 4'h1, 2);
    set_entry(1, 16'hFFFF, 16'hFFFF, 16'hFFFF, OP_ADD, 4'h2, 1); // Largest operands
    set_entry(2, 16'h0002, 16'h0003, 16'h0064, OP_SUB, 4'h3, 3); // Wraps below zero
    set_entry(3, 16'h1234, 16'h5678, 16'h0ABC, OP_SUB, 4'h4, 0); // Back-to-back run starts
    set_entry(4, 16'h00FF, 16'h0101, 16'h0001, OP_ADD, 4'h5, 0);
    set_entry(5, 16'h8000, 16'h0002, 16'hFFFF, OP_SUB, 4'h6, 0);
    set_entry(6, 16'h0000, 16'hABCD, 16'h0010, OP_SUB, 4'h7, 0);
    set_entry(7, 16'h7FFF, 16'h7FFF, 16'h0000, OP_ADD, 4'h8, 0);
    set_entry(8, 16'h0001, 16'h0001, 16'h0001, OP_SUB, 4'h9, 2);
    set_entry(9, 16'hFFFF, 16'h0001, 16'hFFFF, OP_SUB, 4'hA, 1);
    set_entry(10, 16'h0100, 16'h0100, 16'hFFFF, OP_ADD, 4'hB, 3);
    set_entry(11, 16'hCAFE, 16'hBEEF, 16'h1357, OP_ADD, 4'hC, 1);
    for (int i = N_FIXED; i < N_ENTRIES; i++) begin
      set_entry(i, word_t'($random(seed)), word_t'($random(seed)), word_t'($random(seed)),
                ($random(seed) & 1) ? OP_SUB : OP_ADD, tag_t'(i), $random(seed) & 3);
    end
  endtask

  function automatic int max_gap();
    int m;
    m = 0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (tbl_gap[i] > m) m = tbl_gap[i];
    end
    return m;
  endfunction

  // ##################################################
  // Scoreboard side, sampled mid-cycle
  // ##################################################

  always @(negedge clk) begin : monitor
    result_t want_result;
    tag_t want_tag;
    int issue_edge;
    if (reset) begin
      if (cycle >= 1) begin // Registers are cleared from the first edge on
        check_value("done", result_t'(done), '0);
        check_value("result", result, '0);
        check_value("tag_out", result_t'(tag_out), '0);
      end
    end else if (done) begin
      done_count++;
      if (exp_result.size() == 0) begin
        $display("Got a done pulse with no operation in flight at cycle %0d", cycle);
        errors++;
      end else begin
        want_result = exp_result.pop_front();
        want_tag = exp_tag.pop_front();
        issue_edge = exp_edge.pop_front();
        check_value("result", result, want_result);
        check_value("tag_out", result_t'(tag_out), result_t'(want_tag));
        check_value("done_latency", cycle - issue_edge, `MADD_LAT);
        last_result = want_result;
        last_tag = want_tag;
      end
    end else begin
      check_value("result", result, last_result); // Holds between done pulses
      check_value("tag_out", result_t'(tag_out), result_t'(last_tag));
    end
  end

  // ##################################################
  // Stimulus
  // ##################################################

  initial begin
    reset = 1'b1;
    go = 1'b0;
    a = '0;
    b = '0;
    c = '0;
    op = OP_ADD;
    tag = '0;
    fill_table();
    table_ready = 1;
    repeat (16) @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < N_ENTRIES; i++) begin
      go = 1'b1;
      a = tbl_a[i];
      b = tbl_b[i];
      c = tbl_c[i];
      op = tbl_op[i];
      tag = tbl_tag[i];
      exp_result.push_back(expected_result(tbl_a[i], tbl_b[i], tbl_c[i], tbl_op[i]));
      exp_tag.push_back(tbl_tag[i]);
      exp_edge.push_back(cycle);
      go_count++;
      @(negedge clk);
      go = 1'b0;
      repeat (tbl_gap[i]) @(negedge clk);
    end

    repeat (`MADD_LAT + 1) @(negedge clk); // Last done is due here, then result must hold

    check_value("done_count", done_count, go_count);
    if (exp_result.size() != 0) begin
      $display("%0d operations never completed", exp_result.size());
      errors++;
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = 16 + N_ENTRIES * (`MADD_LAT + max_gap()) + 50;
    repeat (limit) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
